// ==== list.f ====
+incdir+design
design/soc_bus_pkg.sv
design/bios_ram.sv
design/io_decoder.sv
design/control_regs.sv
design/mem_arbiter.sv
design/mem_router.sv
design/bus_top.sv
tests/tb_bus_top.sv

// ==== Bender.yml ====
package:
  name: soc_bus_fabric

sources:
  - include_dirs:
      - design
    files:
      - design/soc_bus_pkg.sv
      - design/bios_ram.sv
      - design/io_decoder.sv
      - design/control_regs.sv
      - design/mem_arbiter.sv
      - design/mem_router.sv
      - design/bus_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_bus_top.sv

// ==== tests/tb_bus_top.sv ====
//############################################################################
// Testbench for the bus fabric top. Directed I/O, BIOS and external memory
// tests, then random two-master traffic against a delayed external model.
//############################################################################

`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_bus_top;
    import soc_bus_pkg::*;

    // 2 x 80 random transfers at up to ~16 cycles each, plus directed tests
    localparam int max_cycles = 5000;
    localparam int random_count = 80;

    logic     sys_clk;
    logic     rst_n;
    addr_t    instr_addr;
    logic     instr_access;
    word_t    instr_rdata;
    logic     instr_ack;
    addr_t    data_addr;
    word_t    data_wdata;
    logic     data_wr_en;
    bytesel_t data_bytesel;
    logic     data_access;
    logic     data_io;
    word_t    data_rdata;
    logic     data_ack;
    addr_t    ext_addr;
    word_t    ext_wdata;
    logic     ext_access;
    logic     ext_wr_en;
    bytesel_t ext_bytesel;
    word_t    ext_rdata;
    logic     ext_ack;
    led_t     leds;

    word_t       ext_mem [addr_t];   // External memory contents
    word_t       shadow [addr_t];    // Expected contents from data writes
    int unsigned ext_delay [64];
    int          ext_count = 0;
    addr_t       last_ext_addr;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_base = 0;
    int          cycles = 0;

    bus_top uut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Unwritten words, a pattern over all address bits
    function automatic word_t fill_word(addr_t a);
        return {a[2:0], a[15:3]} ^ {13'h0, a[18:16]} ^ 16'h6B2D;
    endfunction

    function automatic word_t merge_lanes(word_t old, word_t wd, bytesel_t sel);
        word_t w;
        w = old;
        if (sel[0]) w[7:0] = wd[7:0];
        if (sel[1]) w[15:8] = wd[15:8];
        return w;
    endfunction

    function automatic word_t expected_at(addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic addr_t port_addr(io_port_t port);
        return addr_t'(port[15:1]);   // Port bits 15 to 1 on word address
    endfunction

    task automatic flag_error(string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(string what, bit ok);
        checks++;
        assert (ok) else flag_error(what);
    endtask

    task automatic close_test(string name);
        tests++;
        $display("test %0d %-14s %s", tests, name, errors == test_base ? "ok" : "failed");
        test_base = errors;
    endtask

    // One data port transfer, I/O or memory; lat counts cycles to the ack cycle
    task automatic data_transfer(input addr_t a, input bit io, input bit wr,
                                 input word_t wd, input bytesel_t bs,
                                 output word_t rd, output int lat);
        @(posedge sys_clk);
        #1;
        data_addr    = a;
        data_io      = io;
        data_wr_en   = wr;
        data_wdata   = wr ? wd : '0;
        data_bytesel = bs;
        data_access  = 1'b1;
        lat = -1;
        do begin
            @(posedge sys_clk);
            lat++;
        end while (!data_ack);
        rd = data_rdata;
        #1;
        data_access = 1'b0;
        data_wr_en  = 1'b0;
        data_io     = 1'b0;
    endtask

    task automatic instr_fetch(input addr_t a, output word_t rd, output int lat);
        @(posedge sys_clk);
        #1;
        instr_addr   = a;
        instr_access = 1'b1;
        lat = -1;
        do begin
            @(posedge sys_clk);
            lat++;
        end while (!instr_ack);
        rd = instr_rdata;
        #1;
        instr_access = 1'b0;
    endtask

    // Both masters at once, data in its own window, fetches from unwritten words
    task automatic random_traffic(int count);
        fork
            begin
                addr_t    a;
                bit       wr;
                word_t    wd;
                word_t    rd;
                bytesel_t bs;
                int       lat;
                for (int i = 0; i < count; i++) begin
                    a  = 19'h01000 + 19'($urandom % 16);
                    wr = 1'($urandom % 2);
                    wd = 16'($urandom);
                    bs = 2'($urandom % 3 + 1);
                    data_transfer(a, 1'b0, wr, wd, bs, rd, lat);
                    if (wr) begin
                        shadow[a] = merge_lanes(expected_at(a), wd, bs);
                    end else begin
                        check_value("random_data", expected_at(a), rd);
                    end
                end
            end
            begin
                addr_t a;
                word_t rd;
                int    lat;
                for (int i = 0; i < count; i++) begin
                    a = 19'h20000 + 19'($urandom % 256);
                    instr_fetch(a, rd, lat);
                    check_value("random_fetch", fill_word(a), rd);
                end
            end
        join
    endtask

    // External memory with 0 to 5 cycles of ack delay
    initial begin
        addr_t    a;
        bit       wr;
        word_t    wd;
        bytesel_t bs;
        int       n;
        ext_ack   = 1'b0;
        ext_rdata = '0;
        n = 0;
        forever begin
            @(posedge sys_clk);
            if (rst_n && ext_access) begin
                a  = ext_addr;
                wr = ext_wr_en;
                wd = ext_wdata;
                bs = ext_bytesel;
                ext_count++;
                last_ext_addr = a;
                repeat (ext_delay[n % 64]) @(posedge sys_clk);
                n++;
                #1;
                if (wr) begin
                    ext_mem[a] = merge_lanes(ext_mem.exists(a) ? ext_mem[a] : fill_word(a),
                                             wd, bs);
                end else begin
                    ext_rdata = ext_mem.exists(a) ? ext_mem[a] : fill_word(a);
                end
                ext_ack = 1'b1;
                @(posedge sys_clk);
                #1;
                ext_ack   = 1'b0;
                ext_rdata = '0;
            end
        end
    end

    a_acks_apart: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(instr_ack && data_ack && !data_io))
        else flag_error("instruction and data memory acks high in the same cycle");

    a_data_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        data_access && !data_ack |=> data_access && $stable(data_addr)
            && $stable(data_wdata) && $stable(data_io))
        else flag_error("data request changed before its ack");

    a_instr_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        instr_access && !instr_ack |=> instr_access && $stable(instr_addr))
        else flag_error("instruction request changed before its ack");

    a_ext_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        ext_access && !ext_ack |=> ext_access && $stable(ext_addr))
        else flag_error("external request dropped or moved while ack was delayed");

    a_io_latency: assert property (@(posedge sys_clk) disable iff (!rst_n)
        data_access && data_io && !data_ack |=> data_ack)
        else flag_error("I/O ack did not come one cycle after the request");

    a_data_idle_zero: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !data_ack |-> data_rdata == '0)
        else flag_error("data read data nonzero outside the ack cycle");

    a_instr_idle_zero: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !instr_ack |-> instr_rdata == '0)
        else flag_error("instruction read data nonzero outside the ack cycle");

    initial begin
        word_t rd;
        int    lat;
        int    count_before;
        addr_t bios_addr;
        void'($urandom(82401));
        foreach (ext_delay[i]) begin
            ext_delay[i] = $urandom % 6;
        end
        bios_addr    = 19'h7E123;   // Byte address 0xFC246
        rst_n        = 1'b0;
        instr_addr   = '0;
        instr_access = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_wr_en   = 1'b0;
        data_bytesel = '0;
        data_access  = 1'b0;
        data_io      = 1'b0;
        repeat (16) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;

        check_value("reset_leds", 0, leds);
        check_true("ext_access high after reset", !ext_access);
        data_transfer(port_addr(`SOC_IO_BIOS_CTRL_PORT), 1'b1, 1'b0, 0, 2'b11, rd, lat);
        check_value("reset_bios_ctrl", 1, rd);
        data_transfer(port_addr(`SOC_IO_LEDS_PORT), 1'b1, 1'b0, 0, 2'b11, rd, lat);
        check_value("reset_leds_read", 0, rd);
        close_test("reset_state");

        data_transfer(port_addr(`SOC_IO_LEDS_PORT), 1'b1, 1'b1, 16'hA55A, 2'b11, rd, lat);
        check_value("leds_write_lat", 1, lat);
        check_value("leds_out", 8'h5A, leds);
        data_transfer(port_addr(`SOC_IO_LEDS_PORT), 1'b1, 1'b0, 0, 2'b11, rd, lat);
        check_value("leds_readback", 16'h005A, rd);
        check_value("leds_read_lat", 1, lat);
        close_test("leds_reg");

        data_transfer(port_addr(16'h0100), 1'b1, 1'b0, 0, 2'b11, rd, lat);
        check_value("unmapped_read", 0, rd);
        check_value("unmapped_lat", 1, lat);
        close_test("unmapped_port");

        count_before = ext_count;
        data_transfer(bios_addr, 1'b0, 1'b1, 16'hBEEF, 2'b11, rd, lat);
        check_value("bios_write_lat", 2, lat);
        data_transfer(bios_addr, 1'b0, 1'b1, 16'h12AB, 2'b10, rd, lat);
        data_transfer(bios_addr, 1'b0, 1'b0, 0, 2'b11, rd, lat);
        check_value("bios_read", 16'h12EF, rd);
        check_value("bios_read_lat", 2, lat);
        instr_fetch(bios_addr, rd, lat);
        check_value("bios_fetch", 16'h12EF, rd);
        check_true("ext_access rose during a BIOS access", ext_count == count_before);
        close_test("bios_ram");

        data_transfer(port_addr(`SOC_IO_BIOS_CTRL_PORT), 1'b1, 1'b1, 0, 2'b11, rd, lat);
        data_transfer(port_addr(`SOC_IO_BIOS_CTRL_PORT), 1'b1, 1'b0, 0, 2'b11, rd, lat);
        check_value("bios_ctrl_off", 0, rd);
        count_before = ext_count;
        data_transfer(bios_addr, 1'b0, 1'b0, 0, 2'b11, rd, lat);
        check_true("BIOS region read did not reach external memory",
                   ext_count == count_before + 1);
        check_value("bios_off_addr", bios_addr, last_ext_addr);
        check_value("bios_off_read", fill_word(bios_addr), rd);
        close_test("bios_disabled");

        random_traffic(random_count);
        close_test("random_traffic");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== design/bus_top.sv ====
//############################################################################
// Top of the bus fabric. Splits the data port into I/O and memory halves,
// arbitrates memory against instruction fetch and routes to BIOS or external.
//############################################################################

`timescale 1ns/1ps

module bus_top (
    input  logic                  sys_clk,
    input  logic                  rst_n,
    input  soc_bus_pkg::addr_t    instr_addr,
    input  logic                  instr_access,
    output soc_bus_pkg::word_t    instr_rdata,
    output logic                  instr_ack,
    input  soc_bus_pkg::addr_t    data_addr,
    input  soc_bus_pkg::word_t    data_wdata,
    input  logic                  data_wr_en,
    input  soc_bus_pkg::bytesel_t data_bytesel,
    input  logic                  data_access,
    input  logic                  data_io,
    output soc_bus_pkg::word_t    data_rdata,
    output logic                  data_ack,
    output soc_bus_pkg::addr_t    ext_addr,
    output soc_bus_pkg::word_t    ext_wdata,
    output logic                  ext_access,
    output logic                  ext_wr_en,
    output soc_bus_pkg::bytesel_t ext_bytesel,
    input  soc_bus_pkg::word_t    ext_rdata,
    input  logic                  ext_ack,
    output soc_bus_pkg::led_t     leds
);
    import soc_bus_pkg::*;

    logic     leds_sel;
    logic     bios_ctrl_sel;
    word_t    leds_rdata;
    word_t    bios_ctrl_rdata;
    logic     leds_ack;
    logic     bios_ctrl_ack;
    word_t    io_rdata;
    logic     io_ack;
    logic     bios_enabled;
    word_t    mem_rdata;
    logic     mem_ack;
    addr_t    q_addr;
    word_t    q_wdata;
    logic     q_access;
    logic     q_wr_en;
    bytesel_t q_bytesel;
    word_t    q_rdata;
    logic     q_ack;

    io_decoder u_io_decoder (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .data_addr       (data_addr),
        .data_access     (data_access),
        .data_io         (data_io),
        .leds_sel        (leds_sel),
        .bios_ctrl_sel   (bios_ctrl_sel),
        .leds_rdata      (leds_rdata),
        .bios_ctrl_rdata (bios_ctrl_rdata),
        .leds_ack        (leds_ack),
        .bios_ctrl_ack   (bios_ctrl_ack),
        .io_rdata        (io_rdata),
        .io_ack          (io_ack)
    );

    control_regs u_control_regs (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .leds_sel        (leds_sel),
        .bios_ctrl_sel   (bios_ctrl_sel),
        .wr_en           (data_wr_en),
        .wdata           (data_wdata),
        .leds_rdata      (leds_rdata),
        .bios_ctrl_rdata (bios_ctrl_rdata),
        .leds_ack        (leds_ack),
        .bios_ctrl_ack   (bios_ctrl_ack),
        .leds            (leds),
        .bios_enabled    (bios_enabled)
    );

    mem_arbiter u_mem_arbiter (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_rdata  (instr_rdata),
        .instr_ack    (instr_ack),
        .d_addr       (data_addr),
        .d_wdata      (data_wdata),
        .d_access     (data_access & ~data_io),  // Memory half of the data port
        .d_wr_en      (data_wr_en),
        .d_bytesel    (data_bytesel),
        .d_rdata      (mem_rdata),
        .d_ack        (mem_ack),
        .q_addr       (q_addr),
        .q_wdata      (q_wdata),
        .q_access     (q_access),
        .q_wr_en      (q_wr_en),
        .q_bytesel    (q_bytesel),
        .q_rdata      (q_rdata),
        .q_ack        (q_ack)
    );

    mem_router u_mem_router (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .q_addr       (q_addr),
        .q_wdata      (q_wdata),
        .q_access     (q_access),
        .q_wr_en      (q_wr_en),
        .q_bytesel    (q_bytesel),
        .q_rdata      (q_rdata),
        .q_ack        (q_ack),
        .bios_enabled (bios_enabled),
        .ext_addr     (ext_addr),
        .ext_wdata    (ext_wdata),
        .ext_access   (ext_access),
        .ext_wr_en    (ext_wr_en),
        .ext_bytesel  (ext_bytesel),
        .ext_rdata    (ext_rdata),
        .ext_ack      (ext_ack)
    );

    assign data_rdata = data_io ? io_rdata : mem_rdata;
    assign data_ack   = data_io ? io_ack : mem_ack;

endmodule

// ==== design/mem_router.sv ====
//############################################################################
// Routes the shared memory port to the BIOS RAM when the address is in the
// BIOS region and the BIOS is enabled, else to the external memory port.
//############################################################################

`timescale 1ns/1ps
`include "soc_settings.svh"

module mem_router (
    input  logic                  sys_clk,
    input  logic                  rst_n,
    input  soc_bus_pkg::addr_t    q_addr,
    input  soc_bus_pkg::word_t    q_wdata,
    input  logic                  q_access,
    input  logic                  q_wr_en,
    input  soc_bus_pkg::bytesel_t q_bytesel,
    output soc_bus_pkg::word_t    q_rdata,
    output logic                  q_ack,
    input  logic                  bios_enabled,
    output soc_bus_pkg::addr_t    ext_addr,
    output soc_bus_pkg::word_t    ext_wdata,
    output logic                  ext_access,
    output logic                  ext_wr_en,
    output soc_bus_pkg::bytesel_t ext_bytesel,
    input  soc_bus_pkg::word_t    ext_rdata,
    input  logic                  ext_ack
);
    import soc_bus_pkg::*;

    localparam int unsigned tag_w = $bits(`SOC_BIOS_TAG);

    logic  bios_hit;
    logic  bios_cs;
    word_t bios_rdata;
    logic  bios_ack;

    assign bios_hit = bios_enabled &&
                      (q_addr[`SOC_ADDR_WIDTH-1 -: tag_w] == `SOC_BIOS_TAG);

    assign bios_cs    = q_access & bios_hit;
    assign ext_access = q_access & ~bios_hit;
    assign ext_addr    = q_addr;
    assign ext_wdata   = q_wdata;
    assign ext_wr_en   = q_wr_en;
    assign ext_bytesel = q_bytesel;

    bios_ram u_bios_ram (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .cs      (bios_cs),
        .addr    (q_addr),
        .wdata   (q_wdata),
        .wr_en   (q_wr_en),
        .bytesel (q_bytesel),
        .rdata   (bios_rdata),
        .ack     (bios_ack)
    );

    // Both replies are zero outside their ack cycle
    assign q_rdata = bios_rdata | (ext_ack ? ext_rdata : '0);
    assign q_ack   = bios_ack | ext_ack;

endmodule

// ==== design/mem_arbiter.sv ====
//############################################################################
// Shares one memory port between the data and instruction masters. The grant
// is registered and held until the transfer acks; data wins from idle.
//############################################################################

`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  sys_clk,
    input  logic                  rst_n,
    input  soc_bus_pkg::addr_t    instr_addr,
    input  logic                  instr_access,
    output soc_bus_pkg::word_t    instr_rdata,
    output logic                  instr_ack,
    input  soc_bus_pkg::addr_t    d_addr,
    input  soc_bus_pkg::word_t    d_wdata,
    input  logic                  d_access,
    input  logic                  d_wr_en,
    input  soc_bus_pkg::bytesel_t d_bytesel,
    output soc_bus_pkg::word_t    d_rdata,
    output logic                  d_ack,
    output soc_bus_pkg::addr_t    q_addr,
    output soc_bus_pkg::word_t    q_wdata,
    output logic                  q_access,
    output logic                  q_wr_en,
    output soc_bus_pkg::bytesel_t q_bytesel,
    input  soc_bus_pkg::word_t    q_rdata,
    input  logic                  q_ack
);
    import soc_bus_pkg::*;

    arb_state_e state;
    arb_state_e next_state;
    logic       grant_data;
    logic       grant_instr;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (d_access) begin
                    next_state = SERVE_DATA;
                end else if (instr_access) begin
                    next_state = SERVE_INSTR;
                end
            end
            SERVE_DATA, SERVE_INSTR: begin
                if (q_ack) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign grant_data  = (state == SERVE_DATA);
    assign grant_instr = (state == SERVE_INSTR);

    // Owner's request, masters hold it stable until ack
    assign q_access  = grant_data | grant_instr;
    assign q_addr    = grant_data ? d_addr : instr_addr;
    assign q_wdata   = grant_data ? d_wdata : '0;
    assign q_wr_en   = grant_data & d_wr_en;      // Fetches only read
    assign q_bytesel = grant_data ? d_bytesel : '1;

    assign d_rdata     = grant_data ? q_rdata : '0;
    assign d_ack       = grant_data & q_ack;
    assign instr_rdata = grant_instr ? q_rdata : '0;
    assign instr_ack   = grant_instr & q_ack;

    a_acks_exclusive: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(instr_ack && d_ack));

    a_q_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
        q_access && !q_ack |=> q_access && $stable(q_addr) && $stable(q_wr_en));

endmodule

// ==== design/control_regs.sv ====
//############################################################################
// LED and BIOS control registers on the I/O bus. Each register acks one
// cycle after its select; bios_enabled maps the BIOS RAM into memory.
//############################################################################

`timescale 1ns/1ps

module control_regs (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  logic               leds_sel,
    input  logic               bios_ctrl_sel,
    input  logic               wr_en,
    input  soc_bus_pkg::word_t wdata,
    output soc_bus_pkg::word_t leds_rdata,
    output soc_bus_pkg::word_t bios_ctrl_rdata,
    output logic               leds_ack,
    output logic               bios_ctrl_ack,
    output soc_bus_pkg::led_t  leds,
    output logic               bios_enabled
);
    import soc_bus_pkg::*;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            leds          <= '0;
            bios_enabled  <= 1'b1;  // Boot from on-chip BIOS
            leds_ack      <= 1'b0;
            bios_ctrl_ack <= 1'b0;
        end else begin
            leds_ack      <= leds_sel & ~leds_ack;
            bios_ctrl_ack <= bios_ctrl_sel & ~bios_ctrl_ack;

            // Write once, in the first cycle of the access
            if (leds_sel && !leds_ack && wr_en) begin
                leds <= led_t'(wdata);
            end
            if (bios_ctrl_sel && !bios_ctrl_ack && wr_en) begin
                bios_enabled <= wdata[0];
            end
        end
    end

    assign leds_rdata      = leds_ack ? word_t'(leds) : '0;
    assign bios_ctrl_rdata = bios_ctrl_ack ? word_t'(bios_enabled) : '0;

    a_leds_ack_sel: assert property (@(posedge sys_clk) disable iff (!rst_n)
        leds_ack |-> $past(leds_sel));

    a_bios_ack_sel: assert property (@(posedge sys_clk) disable iff (!rst_n)
        bios_ctrl_ack |-> $past(bios_ctrl_sel));

endmodule

// ==== design/io_decoder.sv ====
//############################################################################
// I/O space decoder on the data port. Raises one register select per access
// and answers unmapped ports with a zero-data ack one cycle later.
//############################################################################

`timescale 1ns/1ps
`include "soc_settings.svh"

module io_decoder (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  soc_bus_pkg::addr_t data_addr,
    input  logic               data_access,
    input  logic               data_io,
    output logic               leds_sel,
    output logic               bios_ctrl_sel,
    input  soc_bus_pkg::word_t leds_rdata,
    input  soc_bus_pkg::word_t bios_ctrl_rdata,
    input  logic               leds_ack,
    input  logic               bios_ctrl_ack,
    output soc_bus_pkg::word_t io_rdata,
    output logic               io_ack
);
    import soc_bus_pkg::*;

    io_port_t port;
    logic     default_access;
    logic     default_ack;

    assign port = {data_addr[14:0], 1'b0};  // Byte address bits 15 to 0

    always_comb begin
        leds_sel       = 1'b0;
        bios_ctrl_sel  = 1'b0;
        default_access = 1'b0;
        if (data_access && data_io) begin
            case (port)
                `SOC_IO_LEDS_PORT:      leds_sel = 1'b1;
                `SOC_IO_BIOS_CTRL_PORT: bios_ctrl_sel = 1'b1;
                default:                default_access = 1'b1;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_access & ~default_ack;  // Single pulse
        end
    end

    assign io_rdata = leds_rdata | bios_ctrl_rdata;  // Default slave reads zero
    assign io_ack   = leds_ack | bios_ctrl_ack | default_ack;

    a_one_select: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $onehot0({leds_sel, bios_ctrl_sel, default_access}));

    // Register acks and the default ack must never collide
    a_one_ack: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $onehot0({leds_ack, bios_ctrl_ack, default_ack}));

endmodule

// ==== design/bios_ram.sv ====
//############################################################################
// On-chip BIOS word RAM with byte lane writes. Acks one cycle after chip
// select, with read data driven only in the ack cycle.
//############################################################################

`timescale 1ns/1ps
`include "soc_settings.svh"

module bios_ram (
    input  logic                  sys_clk,
    input  logic                  rst_n,
    input  logic                  cs,
    input  soc_bus_pkg::addr_t    addr,
    input  soc_bus_pkg::word_t    wdata,
    input  logic                  wr_en,
    input  soc_bus_pkg::bytesel_t bytesel,
    output soc_bus_pkg::word_t    rdata,
    output logic                  ack
);
    import soc_bus_pkg::*;

    localparam int unsigned idx_w = $clog2(`SOC_BIOS_DEPTH);

    word_t            mem [`SOC_BIOS_DEPTH];
    word_t            rdata_q;
    logic [idx_w-1:0] idx;
    logic             start;

    assign idx   = addr[idx_w-1:0];
    assign start = cs & ~ack;  // cs stays high through the ack cycle

    always_ff @(posedge sys_clk) begin
        if (start) begin
            if (wr_en && bytesel[0]) begin
                mem[idx][7:0] <= wdata[7:0];
            end
            if (wr_en && bytesel[1]) begin
                mem[idx][15:8] <= wdata[15:8];
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= start;
        end
    end

    assign rdata = ack ? rdata_q : '0;

endmodule

// ==== design/soc_bus_pkg.sv ====
//############################################################################
// Bus types shared by the fabric. Modules name them by scope in their port
// lists and take the package with a wildcard import inside the body.
//############################################################################

`include "soc_settings.svh"

package soc_bus_pkg;

    typedef logic [`SOC_DATA_WIDTH-1:0]   word_t;
    typedef logic [`SOC_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [15:0]                  io_port_t;
    typedef logic [`SOC_DATA_WIDTH/8-1:0] bytesel_t;  // Bit 0 is the low byte
    typedef logic [`SOC_NUM_LEDS-1:0]     led_t;

    // Owner of the shared memory port
    typedef enum logic [1:0] {
        IDLE,
        SERVE_DATA,
        SERVE_INSTR
    } arb_state_e;

endpackage

// ==== design/soc_settings.svh ====
//############################################################################
// Fixed sizes, I/O port numbers and the BIOS region of the SoC bus fabric.
// Included by the bus package and by any RTL that decodes ports or regions.
//############################################################################

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

`define SOC_DATA_WIDTH 16
`define SOC_ADDR_WIDTH 19      // Word address, byte address bits 19 to 1

`define SOC_NUM_LEDS 8

// I/O port numbers, byte addresses within the 64K I/O space
`define SOC_IO_LEDS_PORT      16'hFFFE
`define SOC_IO_BIOS_CTRL_PORT 16'hFFEC

// Top byte-address bits of 0xFC000 to 0xFFFFF
`define SOC_BIOS_TAG   6'b111111
`define SOC_BIOS_DEPTH 8192    // Words

`endif
